//--- files.f
common/ctrlPkg.sv
common/ctrlBus.sv
decode/mainDecoder.sv
decode/aluDecoder.sv
logic/execControl.sv
logic/resultControl.sv
logic/controlUnit.sv
dv/controlUnitTb.sv

//--- dv/controlUnitTb.sv
// Testbench for the control unit
// Directed tests for reset, arithmetic, memory, branch and illegal encodings
// Seeded random instruction stream checked against a queue-based pipeline model
// Typed compare tasks, error counting and a cycle-count timeout
`timescale 1ns/100ps
`default_nettype none

module controlUnitTb;
    import ctrlPkg::*;

    localparam int ResetCycles = 3;
    localparam int DrainCycles = 4;                 // Empties execute, memory and writeback
    localparam int RandomCount = 200;
    localparam int TestCycles  = ResetCycles + (1 + DrainCycles) + (16 + DrainCycles)
                               + (2 + DrainCycles) + (14 + DrainCycles) + (6 + DrainCycles)
                               + (RandomCount + DrainCycles);
    localparam int CycleLimit  = 2 * TestCycles + 20;

    // Expected control of one instruction as it moves down the pipe
    typedef struct packed {
        logic    valid;
        logic    branch;
        logic    jump;
        logic    regWrite;
        logic    memWrite;
        logic    memToReg;
        logic    aluSrc;
        logic    illegal;
        aluCtrlT aluCtrl;
        immSrcT  immSrc;
        regSrcT  regSrc;
        funcT    func;
    } slotT;

    logic    clk, rstN, instrValid;
    opcodeT  opcode;
    sFieldT  s;
    funcT    func;
    flagsT   flags;
    immSrcT  immSrc;
    regSrcT  regSrc;
    aluCtrlT aluCtrl;
    logic    aluSrc, pcSrc, illegalInstr, memWrite, regWrite, memToReg;

    slotT   pipe[$];                                // [0] decode, [1] execute, [2] mem, [3] wb
    slotT   newSlot, exSlot;
    logic   expTaken;
    logic   modelOn;
    integer seed, errorCount, checkCount, cycleCount;

    controlUnit uut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;                          // 40 ns period

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", CycleLimit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic slotT expectedControl(input opcodeT op, input sFieldT sf,
                                             input funcT fn, input logic v);
        slotT e;
        e         = '0;
        e.valid   = v;
        e.func    = fn;
        e.immSrc  = ImmNone;
        e.regSrc  = RegSrcReg;
        e.aluCtrl = AluAdd;                         // Address and jump targets add
        case (op)
            OpArith: begin
                e.regWrite = 1'b1;
                e.aluCtrl  = fn;
                if (fn[1:0] == 2'b11) begin         // sll and srl use a shift amount
                    e.aluSrc = 1'b1;
                    e.immSrc = ImmShift;
                end
            end
            OpArithImm: begin
                e.regWrite = 1'b1;
                e.aluCtrl  = fn;
                e.aluSrc   = 1'b1;
                e.immSrc   = ImmPlain;
            end
            OpMem: begin
                if (sf == SStore || sf == SLoad) begin
                    e.memWrite = (sf == SStore);
                    e.regWrite = (sf == SLoad);
                    e.memToReg = (sf == SLoad);
                    e.aluSrc   = 1'b1;
                    e.immSrc   = ImmPlain;
                end else begin
                    e.illegal = 1'b1;               // Undefined S
                end
            end
            OpBranch: begin
                e.branch  = 1'b1;
                e.regSrc  = RegSrcPc;
                e.jump    = (fn[1:0] == 2'b11);
                e.aluSrc  = e.jump;
                e.immSrc  = e.jump ? ImmJump : ImmPlain;
                e.aluCtrl = e.jump ? AluAdd : AluSub;   // Compares subtract
            end
            default: e.illegal = 1'b1;              // Vector and management opcodes
        endcase
        return e;
    endfunction

    task automatic checkAluCtrl(input aluCtrlT got, input aluCtrlT exp, input string what);
        checkCount = checkCount + 1;
        if (got !== exp) begin
            errorCount = errorCount + 1;
            $display("MISMATCH @%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkImmSrc(input immSrcT got, input immSrcT exp, input string what);
        checkCount = checkCount + 1;
        if (got !== exp) begin
            errorCount = errorCount + 1;
            $display("MISMATCH @%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkRegSrc(input regSrcT got, input regSrcT exp, input string what);
        checkCount = checkCount + 1;
        if (got !== exp) begin
            errorCount = errorCount + 1;
            $display("MISMATCH @%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        checkCount = checkCount + 1;
        if (got !== exp) begin
            errorCount = errorCount + 1;
            $display("MISMATCH @%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Model step and output compare in the middle of each cycle
    always @(negedge clk) begin
        if (modelOn) begin
            newSlot = expectedControl(opcode, s, func, instrValid);
            pipe.push_front(newSlot);
            pipe.delete(4);
            exSlot   = pipe[1];
            expTaken = exSlot.valid && exSlot.branch && (exSlot.jump
                     || (exSlot.func == FnBeq && flags[FlagZ])
                     || (exSlot.func == FnBne && !flags[FlagZ])
                     || (exSlot.func == FnBlt && flags[FlagN]));
            if (instrValid) begin
                checkImmSrc(immSrc, newSlot.immSrc, "immSrc");
                checkRegSrc(regSrc, newSlot.regSrc, "regSrc");
            end
            if (exSlot.valid) begin
                checkAluCtrl(aluCtrl, exSlot.aluCtrl, "aluCtrl");
                checkBit(aluSrc, exSlot.aluSrc, "aluSrc");
            end
            checkBit(pcSrc, expTaken, "pcSrc");
            checkBit(illegalInstr, exSlot.valid && exSlot.illegal, "illegalInstr");
            checkBit(memWrite, pipe[2].valid && pipe[2].memWrite, "memWrite");
            checkBit(regWrite, pipe[3].valid && pipe[3].regWrite, "regWrite");
            checkBit(memToReg, pipe[3].valid && pipe[3].memToReg, "memToReg");
            if (expTaken) begin
                newSlot       = pipe[0];
                newSlot.valid = 1'b0;               // Younger instruction is flushed
                pipe[0]       = newSlot;
            end
        end
    end

    task automatic driveInstr(input logic v, input opcodeT op, input sFieldT sf,
                              input funcT fn, input flagsT fl);
        @(posedge clk);
        instrValid <= v;
        opcode     <= op;
        s          <= sf;
        func       <= fn;
        flags      <= fl;                           // Applies to the instruction in execute
    endtask

    task automatic idleCycles(input int n);
        repeat (n) driveInstr(1'b0, OpArith, SStore, 3'b000, 4'b0000);
    endtask

    // Load, store and illegal words sent during reset would still be in the pipe
    task automatic resetTest();
        @(negedge clk);
        checkBit(pcSrc, 1'b0, "pcSrc after reset");
        checkBit(illegalInstr, 1'b0, "illegalInstr after reset");
        checkBit(memWrite, 1'b0, "memWrite after reset");
        checkBit(regWrite, 1'b0, "regWrite after reset");
        idleCycles(DrainCycles);
    endtask

    task automatic arithTest();
        int f;
        for (f = 0; f < 8; f++) driveInstr(1'b1, OpArith, SStore, funcT'(f), 4'b0000);
        for (f = 0; f < 8; f++) driveInstr(1'b1, OpArithImm, SStore, funcT'(f), 4'b0000);
        idleCycles(DrainCycles);
    endtask

    task automatic memTest();
        driveInstr(1'b1, OpMem, SStore, 3'b000, 4'b0000);
        driveInstr(1'b1, OpMem, SLoad, 3'b000, 4'b0000);
        idleCycles(DrainCycles);
    endtask

    // Each branch is followed by a younger instruction carrying its execute flags
    task automatic branchTest();
        driveInstr(1'b1, OpBranch, SStore, FnBeq, 4'b0000);
        driveInstr(1'b1, OpArith, SStore, 3'b000, 4'b0100);     // Z set, taken
        driveInstr(1'b1, OpBranch, SStore, FnBeq, 4'b0000);
        driveInstr(1'b1, OpMem, SStore, 3'b000, 4'b0000);       // Not taken, store proceeds
        driveInstr(1'b1, OpBranch, SStore, FnBne, 4'b0000);
        driveInstr(1'b1, OpMem, SStore, 3'b000, 4'b0000);       // Z clear, taken
        driveInstr(1'b1, OpBranch, SStore, FnBne, 4'b0000);
        driveInstr(1'b1, OpArith, SStore, 3'b100, 4'b0100);
        driveInstr(1'b1, OpBranch, SStore, FnBlt, 4'b0000);
        driveInstr(1'b1, OpMem, SLoad, 3'b000, 4'b1000);        // N set, taken
        driveInstr(1'b1, OpBranch, SStore, FnBlt, 4'b0000);
        driveInstr(1'b1, OpArith, SStore, 3'b010, 4'b0001);
        driveInstr(1'b1, OpBranch, SStore, FnJump, 4'b0000);
        driveInstr(1'b1, OpMgmt, SStore, 3'b000, 4'b0010);      // Flushed, no illegal pulse
        idleCycles(DrainCycles);
    endtask

    task automatic illegalTest();
        driveInstr(1'b1, OpVecArith, SStore, 3'b000, 4'b0000);
        driveInstr(1'b1, OpVecMgmt, SStore, 3'b001, 4'b0000);
        driveInstr(1'b1, OpVecMem, SLoad, 3'b010, 4'b0000);
        driveInstr(1'b1, OpMgmt, SStore, 3'b011, 4'b0000);
        driveInstr(1'b1, OpMem, 2'b10, 3'b000, 4'b0000);
        driveInstr(1'b1, OpMem, 2'b11, 3'b000, 4'b0000);
        idleCycles(DrainCycles);
    endtask

    task automatic randomTest();
        logic [31:0] rnd;
        int          i;
        for (i = 0; i < RandomCount; i++) begin
            rnd = $random(seed);
            driveInstr(1'b1, rnd[2:0], rnd[4:3], rnd[7:5], rnd[11:8]);
        end
        idleCycles(DrainCycles);
    endtask

    initial begin
        rstN       = 1'b0;
        instrValid = 1'b1;                          // Valid load while reset is held
        opcode     = OpMem;
        s          = SLoad;
        func       = 3'b000;
        flags      = 4'b0000;
        seed       = 7;
        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        modelOn    = 1'b0;
        repeat (4) pipe.push_back(slotT'(0));       // Empty pipe after reset
        driveInstr(1'b1, OpMem, SStore, 3'b000, 4'b0000);
        driveInstr(1'b1, OpMgmt, SStore, 3'b000, 4'b0000);
        @(posedge clk);
        rstN       <= 1'b1;
        instrValid <= 1'b0;
        modelOn    = 1'b1;
        resetTest();
        arithTest();
        memTest();
        branchTest();
        illegalTest();
        randomTest();
        $display("Checks run: %0d, mismatches: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/controlUnit.sv
// Control unit top level
// Decoders, execute stage and memory and writeback stages
// Datapath signals enter and leave as plain ports
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
    input  wire logic             clk,
    input  wire logic             rstN,
    input  wire logic             instrValid,
    input  wire ctrlPkg::opcodeT  opcode,
    input  wire ctrlPkg::sFieldT  s,
    input  wire ctrlPkg::funcT    func,
    input  wire ctrlPkg::flagsT   flags,
    output ctrlPkg::immSrcT       immSrc,
    output ctrlPkg::regSrcT       regSrc,
    output ctrlPkg::aluCtrlT      aluCtrl,
    output logic                  aluSrc,
    output logic                  pcSrc,
    output logic                  illegalInstr,
    output logic                  memWrite,
    output logic                  regWrite,
    output logic                  memToReg
);

    logic aluOp;                                    // Main decoder to ALU decoder
    logic exValid;
    logic exRegWrite;
    logic exMemWrite;
    logic exMemToReg;

    ctrlBus bus ();                                 // Decoded word into execute

    mainDecoder uMainDecoder (
        .opcode     (opcode),
        .s          (s),
        .func       (func),
        .instrValid (instrValid),
        .immSrc     (immSrc),
        .regSrc     (regSrc),
        .aluOp      (aluOp),
        .bus        (bus)
    );

    aluDecoder uAluDecoder (
        .aluOp   (aluOp),
        .branch  (bus.branch),
        .func    (func),
        .aluCtrl (bus.aluCtrl)
    );

    execControl uExecControl (
        .clk (clk), .rstN (rstN), .bus (bus), .flags (flags),
        .aluCtrl (aluCtrl), .aluSrc (aluSrc), .pcSrc (pcSrc),
        .illegalInstr (illegalInstr), .exValid (exValid), .exRegWrite (exRegWrite),
        .exMemWrite (exMemWrite), .exMemToReg (exMemToReg)
    );

    resultControl uResultControl (
        .clk (clk), .rstN (rstN), .exValid (exValid), .exRegWrite (exRegWrite),
        .exMemWrite (exMemWrite), .exMemToReg (exMemToReg),
        .memWrite (memWrite), .regWrite (regWrite), .memToReg (memToReg)
    );

endmodule

`default_nettype wire

//--- logic/resultControl.sv
// Memory and writeback stage control
// Two register stages carry the write enables after execute
`timescale 1ns/100ps
`default_nettype none

module resultControl (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic exValid,
    input  wire logic exRegWrite,
    input  wire logic exMemWrite,
    input  wire logic exMemToReg,
    output logic      memWrite,
    output logic      regWrite,
    output logic      memToReg
);

    logic memRegWrite;                              // Enables waiting in memory stage
    logic memMemToReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memWrite    <= 1'b0;
            memRegWrite <= 1'b0;
            memMemToReg <= 1'b0;
            regWrite    <= 1'b0;
            memToReg    <= 1'b0;
        end else begin
            memWrite    <= exValid && exMemWrite;   // Flushed slots write nothing
            memRegWrite <= exValid && exRegWrite;
            memMemToReg <= exValid && exMemToReg;
            regWrite    <= memRegWrite;             // Writeback stage
            memToReg    <= memMemToReg;
        end
    end

    // Loaded data always lands in the register file
    memToRegWrites: assert property (
        @(posedge clk) disable iff (!rstN) memToReg |-> regWrite
    ) else $error("memToReg without regWrite in writeback");

endmodule

`default_nettype wire

//--- logic/execControl.sv
// Execute stage control
// Decode-to-execute register with flush on a taken branch
// Branch resolution from the ALU flags and the illegal pulse
`timescale 1ns/100ps
`default_nettype none

module execControl (
    input  wire logic           clk,
    input  wire logic           rstN,
    ctrlBus.execute             bus,
    input  wire ctrlPkg::flagsT flags,
    output ctrlPkg::aluCtrlT    aluCtrl,
    output logic                aluSrc,
    output logic                pcSrc,
    output logic                illegalInstr,
    output logic                exValid,
    output logic                exRegWrite,
    output logic                exMemWrite,
    output logic                exMemToReg
);
    import ctrlPkg::*;

    logic branchQ;                                  // Registered branch bit
    logic jumpQ;
    logic illegalQ;
    funcT funcQ;                                    // Selects the branch condition
    logic taken;                                    // Condition met by the flags

    // Younger instruction is dropped when this one redirects the PC
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exValid <= 1'b0;
        end else begin
            exValid <= bus.valid && !pcSrc;
        end
    end

    always_ff @(posedge clk) begin
        branchQ    <= bus.branch;
        jumpQ      <= bus.jump;
        illegalQ   <= bus.illegal;
        funcQ      <= bus.func;
        aluCtrl    <= bus.aluCtrl;
        aluSrc     <= bus.aluSrc;
        exRegWrite <= bus.regWrite;                 // Gated by exValid downstream
        exMemWrite <= bus.memWrite;
        exMemToReg <= bus.memToReg;
    end

    always_comb begin
        if (jumpQ) begin
            taken = 1'b1;
        end else begin
            case (funcQ)
                FnBeq:   taken = flags[FlagZ];
                FnBne:   taken = !flags[FlagZ];
                FnBlt:   taken = flags[FlagN];      // Sign of a - b
                default: taken = 1'b0;              // Unused branch forms
            endcase
        end
    end

    assign pcSrc        = exValid && branchQ && taken;
    assign illegalInstr = exValid && illegalQ;      // One pulse per illegal instruction

    // Redirect only comes from a valid branch decoded in the cycle before
    pcSrcOnBranch: assert property (
        @(posedge clk) disable iff (!rstN) pcSrc |-> $past(bus.valid && bus.branch)
    ) else $error("pcSrc high without a valid branch decoded the cycle before");

endmodule

`default_nettype wire

//--- decode/aluDecoder.sv
// ALU decoder
// Picks the ALU operation from ALU-op, the branch bit and func
`timescale 1ns/100ps
`default_nettype none

module aluDecoder (
    input  wire logic          aluOp,
    input  wire logic          branch,
    input  wire ctrlPkg::funcT func,
    output ctrlPkg::aluCtrlT   aluCtrl
);
    import ctrlPkg::*;

    always_comb begin
        if (!aluOp) begin
            aluCtrl = AluAdd;                       // Address or jump target
        end else if (branch) begin
            aluCtrl = AluSub;                       // Compare sets the flags
        end else begin
            aluCtrl = aluCtrlT'(func);              // Arithmetic func is the ALU code
        end
    end

endmodule

`default_nettype wire

//--- decode/mainDecoder.sv
// Main decoder of the control path
// Opcode, S and function fields to the control word and the illegal flag
// Vector, management and undefined S encodings write nothing
`timescale 1ns/100ps
`default_nettype none

module mainDecoder (
    input  wire ctrlPkg::opcodeT opcode,
    input  wire ctrlPkg::sFieldT s,
    input  wire ctrlPkg::funcT   func,
    input  wire logic            instrValid,
    output ctrlPkg::immSrcT      immSrc,
    output ctrlPkg::regSrcT      regSrc,
    output logic                 aluOp,
    ctrlBus.decode               bus
);
    import ctrlPkg::*;

    assign bus.valid = instrValid;                  // Level, no handshake
    assign bus.func  = func;                        // Needed again in execute

    always_comb begin
        immSrc       = ImmNone;                     // Safe defaults, nothing written
        regSrc       = RegSrcReg;
        aluOp        = 1'b0;
        bus.branch   = 1'b0;
        bus.jump     = 1'b0;
        bus.regWrite = 1'b0;
        bus.memWrite = 1'b0;
        bus.memToReg = 1'b0;
        bus.aluSrc   = 1'b0;
        bus.illegal  = 1'b0;
        case (opcode)
            OpArith: begin
                bus.regWrite = 1'b1;
                aluOp        = 1'b1;                // Operation from func
                if (func[1:0] == FnShiftLow) begin
                    bus.aluSrc = 1'b1;              // sll and srl take an amount
                    immSrc     = ImmShift;
                end
            end
            OpArithImm: begin
                bus.regWrite = 1'b1;
                aluOp        = 1'b1;
                bus.aluSrc   = 1'b1;
                immSrc       = ImmPlain;
            end
            OpMem: begin
                case (s)
                    SStore: begin
                        bus.memWrite = 1'b1;        // Address is base plus offset
                        bus.aluSrc   = 1'b1;
                        immSrc       = ImmPlain;
                    end
                    SLoad: begin
                        bus.regWrite = 1'b1;
                        bus.memToReg = 1'b1;        // Result comes from memory
                        bus.aluSrc   = 1'b1;
                        immSrc       = ImmPlain;
                    end
                    default: begin
                        bus.illegal = 1'b1;         // S of 10 or 11
                    end
                endcase
            end
            OpBranch: begin
                bus.branch = 1'b1;
                regSrc     = RegSrcPc;
                if (func[1:0] == FnJump[1:0]) begin
                    bus.jump   = 1'b1;              // PC plus offset, add
                    bus.aluSrc = 1'b1;
                    immSrc     = ImmJump;
                end else begin
                    aluOp  = 1'b1;                  // Compare with sub
                    immSrc = ImmPlain;
                end
            end
            OpVecArith, OpVecMgmt, OpVecMem, OpMgmt: begin
                bus.illegal = 1'b1;                 // No vector or management datapath
            end
        endcase
    end

endmodule

`default_nettype wire

//--- common/ctrlBus.sv
// Decoded control word of one instruction
// decode modport for the decoders, execute modport for the execute stage
`timescale 1ns/100ps
`default_nettype none

interface ctrlBus;
    import ctrlPkg::*;

    logic    valid;                                 // Real instruction present
    logic    branch;                                // Any branch or jump
    logic    jump;                                  // Unconditional form
    logic    regWrite;
    logic    memWrite;
    logic    memToReg;                              // Writeback from memory
    logic    aluSrc;                                // Second operand is the immediate
    aluCtrlT aluCtrl;
    funcT    func;                                  // Kept for branch resolution
    logic    illegal;                               // Undefined encoding

    modport decode (
        output valid, branch, jump, regWrite, memWrite, memToReg,
        output aluSrc, aluCtrl, func, illegal
    );

    modport execute (
        input valid, branch, jump, regWrite, memWrite, memToReg,
        input aluSrc, aluCtrl, func, illegal
    );

endinterface

`default_nettype wire

//--- common/ctrlPkg.sv
// Shared control-path definitions
// Field and selector types for the decoder and pipeline stages
// Opcode, memory-access, branch-function and selector encodings
// ALU operation codes and flag bit positions
`default_nettype none

package ctrlPkg;

    typedef logic [2:0] opcodeT;                    // Major opcode
    typedef logic [2:0] funcT;                      // Function field
    typedef logic [1:0] sFieldT;                    // Memory-access selector
    typedef logic [1:0] regSrcT;                    // Register-source select, bit 0 picks PC
    typedef logic [1:0] immSrcT;                    // Immediate-extension select
    typedef logic [2:0] aluCtrlT;                   // ALU operation
    typedef logic [3:0] flagsT;                     // ALU flags, N Z C V

    localparam opcodeT OpArith    = 3'b000;         // Scalar arithmetic and shifts
    localparam opcodeT OpVecArith = 3'b001;         // Vector arithmetic
    localparam opcodeT OpArithImm = 3'b010;         // Scalar immediate arithmetic
    localparam opcodeT OpMem      = 3'b011;         // Scalar load and store
    localparam opcodeT OpVecMgmt  = 3'b100;         // Vector management
    localparam opcodeT OpVecMem   = 3'b101;         // Vector memory access
    localparam opcodeT OpBranch   = 3'b110;         // Branches and jump
    localparam opcodeT OpMgmt     = 3'b111;         // Datapath management

    localparam funcT FnBeq  = 3'b000;               // Branch on equal
    localparam funcT FnBne  = 3'b001;               // Branch on not equal
    localparam funcT FnBlt  = 3'b010;               // Branch on less than
    localparam funcT FnJump = 3'b011;               // Unconditional jump

    // Low two function bits that mark a shift in the arithmetic group
    localparam logic [1:0] FnShiftLow = 2'b11;

    localparam sFieldT SStore = 2'b00;              // str
    localparam sFieldT SLoad  = 2'b01;              // ldr

    localparam regSrcT RegSrcReg = 2'b00;           // Operands from the register file
    localparam regSrcT RegSrcPc  = 2'b01;           // First operand is the PC

    localparam immSrcT ImmPlain = 2'b00;            // Plain immediate
    localparam immSrcT ImmJump  = 2'b01;            // Jump offset
    localparam immSrcT ImmNone  = 2'b10;            // No immediate
    localparam immSrcT ImmShift = 2'b11;            // Shift amount

    // ALU codes used by the decoder, the rest come straight from func
    localparam aluCtrlT AluAdd = 3'b000;
    localparam aluCtrlT AluSub = 3'b001;

    localparam int FlagN = 3;                       // Negative flag position
    localparam int FlagZ = 2;                       // Zero flag position

endpackage

`default_nettype wire
